/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing
TOP      := tb_rv_pipe
FILELIST := src.f
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* rtl/decode_regread.sv */
// rv32i alu subset plus lui/auipc only; anything else, or valid low, becomes a bubble
`default_nettype none
`timescale 1ns/1ps

`include "rv_pipe_config.svh"

module decode_regread (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire rv_pipe_pkg::instr_word_u  instr_i,
    input  wire logic                      instr_valid_i,
    input  wire logic [`RV_XLEN-1:0]       pc_i,
    output logic [`RV_REG_ADDR_W-1:0]      rs1_o,
    output logic [`RV_REG_ADDR_W-1:0]      rs2_o,
    input  wire logic [`RV_XLEN-1:0]       rf_a_i,
    input  wire logic [`RV_XLEN-1:0]       rf_b_i,
    input  wire rv_pipe_pkg::fwd_sel_e     fwd_a_i,
    input  wire rv_pipe_pkg::fwd_sel_e     fwd_b_i,
    input  wire logic [`RV_XLEN-1:0]       exec_result_i,
    input  wire rv_pipe_pkg::ex_to_wb_t    wb_i,
    output rv_pipe_pkg::dec_to_ex_t        ex_o
);

    import rv_pipe_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    uop_e                uop_d;
    logic                use_imm;   // operand b from immediate
    logic                a_zero;    // lui
    logic                a_pc;      // auipc
    logic [`RV_XLEN-1:0] imm_d;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    dec_to_ex_t          ex_d;

    // alt picks sub/sra, the bit 30 variants
    function automatic uop_e alu_uop(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? UOP_SUB : UOP_ADD;
            3'b001:  return UOP_SLL;
            3'b010:  return UOP_SLT;
            3'b011:  return UOP_SLTU;
            3'b100:  return UOP_XOR;
            3'b101:  return alt ? UOP_SRA : UOP_SRL;
            3'b110:  return UOP_OR;
            default: return UOP_AND;
        endcase
    endfunction

    function automatic logic [`RV_XLEN-1:0] fwd_value(input fwd_sel_e sel,
                                                      input logic [`RV_XLEN-1:0] rf);
        case (sel)
            FWD_EXEC: return exec_result_i;
            FWD_WB:   return wb_i.value;
            default:  return rf;
        endcase
    endfunction

    assign rs1_o = instr_i.r_view.rs1;
    assign rs2_o = instr_i.r_view.rs2;

    always_comb begin
        uop_d   = UOP_INVALID;
        use_imm = 1'b0;
        a_zero  = 1'b0;
        a_pc    = 1'b0;
        // i immediate unless a later branch says otherwise
        imm_d   = {{(`RV_XLEN-12){instr_i.i_view.imm_11_0[11]}}, instr_i.i_view.imm_11_0};

        case (instr_i.r_view.opcode)
            OPC_OP: begin
                if (instr_i.r_view.funct7 == 7'b0000000) begin
                    uop_d = alu_uop(instr_i.r_view.funct3, 1'b0);
                end else if (instr_i.r_view.funct7 == 7'b0100000 &&
                             (instr_i.r_view.funct3 == 3'b000 ||
                              instr_i.r_view.funct3 == 3'b101)) begin
                    uop_d = alu_uop(instr_i.r_view.funct3, 1'b1);
                end
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                case (instr_i.i_view.funct3)
                    3'b001: begin  // slli, upper bits must be zero
                        if (instr_i.r_view.funct7 == 7'b0000000) begin
                            uop_d = UOP_SLL;
                        end
                        imm_d = {{(`RV_XLEN-`RV_SHAMT_W){1'b0}}, instr_i.r_view.rs2};
                    end
                    3'b101: begin
                        if (instr_i.r_view.funct7 == 7'b0000000) begin
                            uop_d = UOP_SRL;
                        end else if (instr_i.r_view.funct7 == 7'b0100000) begin
                            uop_d = UOP_SRA;
                        end
                        imm_d = {{(`RV_XLEN-`RV_SHAMT_W){1'b0}}, instr_i.r_view.rs2};
                    end
                    default: uop_d = alu_uop(instr_i.i_view.funct3, 1'b0);  // no subi
                endcase
            end
            OPC_LUI: begin
                uop_d   = UOP_ADD;   // 0 + imm
                use_imm = 1'b1;
                a_zero  = 1'b1;
                imm_d   = {instr_i.su_view.imm_31_12, 12'h000};
            end
            OPC_AUIPC: begin
                uop_d   = UOP_ADD;   // pc + imm
                use_imm = 1'b1;
                a_pc    = 1'b1;
                imm_d   = {instr_i.su_view.imm_31_12, 12'h000};
            end
            default: ;
        endcase

        if (!instr_valid_i) begin
            uop_d = UOP_INVALID;
        end
    end

    assign rs1_val = fwd_value(fwd_a_i, rf_a_i);
    assign rs2_val = fwd_value(fwd_b_i, rf_b_i);

    always_comb begin
        ex_d.valid     = (uop_d != UOP_INVALID);
        ex_d.uop       = uop_d;
        ex_d.writes_rd = (instr_i.r_view.rd != '0);
        ex_d.rd        = instr_i.r_view.rd;
        ex_d.op_a      = a_zero ? '0 : (a_pc ? pc_i : rs1_val);
        ex_d.op_b      = use_imm ? imm_d : rs2_val;
    end

    // reset clears only the valid bit
    always_ff @(posedge clk_i) begin
        ex_o <= ex_d;
        if (rst_i) begin
            ex_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
// single-cycle alu; shift amount is op_b[4:0], result is visible for forwarding before the edge
`default_nettype none
`timescale 1ns/1ps

`include "rv_pipe_config.svh"

module execute_stage (
    input  wire logic                    clk_i,
    input  wire logic                    rst_i,
    input  wire rv_pipe_pkg::dec_to_ex_t ex_i,
    output logic [`RV_XLEN-1:0]          exec_result_o,
    output rv_pipe_pkg::ex_to_wb_t       wb_o
);

    import rv_pipe_pkg::*;

    logic [`RV_SHAMT_W-1:0] shamt;
    logic                   lt_signed;
    logic                   lt_unsigned;
    logic [`RV_XLEN-1:0]    result;
    ex_to_wb_t              wb_d;

    assign shamt       = ex_i.op_b[`RV_SHAMT_W-1:0];
    assign lt_signed   = ($signed(ex_i.op_a) < $signed(ex_i.op_b));
    assign lt_unsigned = (ex_i.op_a < ex_i.op_b);

    always_comb begin
        case (ex_i.uop)
            UOP_ADD:  result = ex_i.op_a + ex_i.op_b;
            UOP_SUB:  result = ex_i.op_a - ex_i.op_b;
            UOP_AND:  result = ex_i.op_a & ex_i.op_b;
            UOP_OR:   result = ex_i.op_a | ex_i.op_b;
            UOP_XOR:  result = ex_i.op_a ^ ex_i.op_b;
            UOP_SLL:  result = ex_i.op_a << shamt;
            UOP_SRL:  result = ex_i.op_a >> shamt;
            UOP_SRA:  result = $signed(ex_i.op_a) >>> shamt;  // sign fill
            UOP_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            UOP_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            default:  result = '0;   // bubble
        endcase
    end

    assign exec_result_o = result;

    always_comb begin
        wb_d.valid = ex_i.valid && ex_i.writes_rd;  // rd x0 never retires
        wb_d.rd    = ex_i.rd;
        wb_d.value = result;
    end

    always_ff @(posedge clk_i) begin
        wb_o <= wb_d;
        if (rst_i) begin
            wb_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/forward_ctrl.sv */
// compares addresses only; decode decides on its own whether operand b is an immediate
`default_nettype none
`timescale 1ns/1ps

`include "rv_pipe_config.svh"

module forward_ctrl (
    input  wire logic [`RV_REG_ADDR_W-1:0] rs1_i,
    input  wire logic [`RV_REG_ADDR_W-1:0] rs2_i,
    input  wire rv_pipe_pkg::dec_to_ex_t   ex_i,
    input  wire rv_pipe_pkg::ex_to_wb_t    wb_i,
    output rv_pipe_pkg::fwd_sel_e          fwd_a_o,
    output rv_pipe_pkg::fwd_sel_e          fwd_b_o
);

    import rv_pipe_pkg::*;

    // younger producer in execute wins over writeback
    function automatic fwd_sel_e pick_source(input logic [`RV_REG_ADDR_W-1:0] rs);
        fwd_sel_e sel;
        sel = FWD_REGFILE;
        if (rs != '0) begin  // x0 never forwarded
            if (ex_i.valid && ex_i.writes_rd && (ex_i.rd == rs)) begin
                sel = FWD_EXEC;
            end else if (wb_i.valid && (wb_i.rd == rs)) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    assign fwd_a_o = pick_source(rs1_i);
    assign fwd_b_o = pick_source(rs2_i);

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
// x0 reads as zero and ignores writes; no write-to-read bypass, forwarding must cover it
`default_nettype none
`timescale 1ns/1ps

`include "rv_pipe_config.svh"

module reg_file (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire logic [`RV_REG_ADDR_W-1:0] rd_addr_a_i,
    input  wire logic [`RV_REG_ADDR_W-1:0] rd_addr_b_i,
    output logic [`RV_XLEN-1:0]            rd_data_a_o,
    output logic [`RV_XLEN-1:0]            rd_data_b_o,
    input  wire rv_pipe_pkg::ex_to_wb_t    wr_i
);

    logic [`RV_XLEN-1:0] regs_q [`RV_NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.valid && (wr_i.rd != '0)) begin
            regs_q[wr_i.rd] <= wr_i.value;
        end
    end

    // x0 forced to zero on the read side
    assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs_q[rd_addr_a_i];
    assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs_q[rd_addr_b_i];

endmodule

`default_nettype wire

/* rtl/rv_pipe_config.svh */
// rv32i only: the decoder and the instruction union assume a 32-bit word and 32 registers
`ifndef RV_PIPE_CONFIG_SVH
`define RV_PIPE_CONFIG_SVH

// datapath width
`define RV_XLEN 32

// register file addressing
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS 32

// shift amount bits taken from operand b
`define RV_SHAMT_W 5

`endif

/* rtl/rv_pipe_pkg.sv */
// types for the 3-stage pipeline; field layouts assume the 32-bit base encoding
`default_nettype none

`include "rv_pipe_config.svh"

package rv_pipe_pkg;

    // alu operation carried down the pipe, zero means bubble
    typedef enum logic [3:0] {
        UOP_INVALID = 4'd0,
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_SLL,
        UOP_SRL,
        UOP_SRA,
        UOP_SLT,
        UOP_SLTU
    } uop_e;

    // where an operand comes from
    typedef enum logic [1:0] {
        FWD_REGFILE = 2'd0,
        FWD_EXEC,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [6:0]                funct7;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0]               imm_11_0;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } i_view_t;

    // the 20 upper bits, split the way an S-type word uses them
    typedef struct packed {
        logic [6:0]                imm_11_5;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
    } upper_fields_t;

    typedef struct packed {
        upper_fields_t             imm_31_12;
        logic [`RV_REG_ADDR_W-1:0] rd;      // imm[4:0] for S
        logic [6:0]                opcode;
    } su_view_t;

    typedef union packed {
        r_view_t  r_view;
        i_view_t  i_view;
        su_view_t su_view;
    } instr_word_u;

    // decode register, consumed by execute
    typedef struct packed {
        logic                      valid;
        uop_e                      uop;
        logic                      writes_rd;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       op_a;
        logic [`RV_XLEN-1:0]       op_b;
    } dec_to_ex_t;

    // writeback record, also the register file write port
    typedef struct packed {
        logic                      valid;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       value;
    } ex_to_wb_t;

endpackage

`default_nettype wire

/* rtl/rv_pipe_top.sv */
// no stalls or back-pressure: one instruction per cycle, retire exactly two cycles later
`default_nettype none
`timescale 1ns/1ps

`include "rv_pipe_config.svh"

module rv_pipe_top (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire logic [`RV_XLEN-1:0]       instr_i,
    input  wire logic                      instr_valid_i,
    input  wire logic [`RV_XLEN-1:0]       pc_i,
    output logic                           retire_valid_o,
    output logic [`RV_REG_ADDR_W-1:0]      retire_rd_o,
    output logic [`RV_XLEN-1:0]            retire_value_o
);

    import rv_pipe_pkg::*;

    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_XLEN-1:0]       rf_a;
    logic [`RV_XLEN-1:0]       rf_b;
    fwd_sel_e                  fwd_a;
    fwd_sel_e                  fwd_b;
    logic [`RV_XLEN-1:0]       exec_result;
    dec_to_ex_t                ex;     // decode register
    ex_to_wb_t                 wb;     // writeback record

    decode_regread decode_regread_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .pc_i          (pc_i),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rf_a_i        (rf_a),
        .rf_b_i        (rf_b),
        .fwd_a_i       (fwd_a),
        .fwd_b_i       (fwd_b),
        .exec_result_i (exec_result),
        .wb_i          (wb),
        .ex_o          (ex)
    );

    forward_ctrl forward_ctrl_inst (
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .ex_i    (ex),
        .wb_i    (wb),
        .fwd_a_o (fwd_a),
        .fwd_b_o (fwd_b)
    );

    reg_file reg_file_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rd_addr_a_i (rs1),
        .rd_addr_b_i (rs2),
        .rd_data_a_o (rf_a),
        .rd_data_b_o (rf_b),
        .wr_i        (wb)
    );

    execute_stage execute_stage_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .ex_i          (ex),
        .exec_result_o (exec_result),
        .wb_o          (wb)
    );

    // retire straight from the writeback record
    assign retire_valid_o = wb.valid;
    assign retire_rd_o    = wb.rd;
    assign retire_value_o = wb.value;

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/rv_pipe_pkg.sv
rtl/reg_file.sv
rtl/forward_ctrl.sv
rtl/decode_regread.sv
rtl/execute_stage.sv
rtl/rv_pipe_top.sv
test/tb_retire_checker.sv
test/tb_rv_pipe.sv

/* test/tb_retire_checker.sv */
// expects retires in the order they were pushed, each exactly two cycles after its input row
`default_nettype none
`timescale 1ns/1ps

`include "rv_pipe_config.svh"

module tb_retire_checker (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    input  wire rv_pipe_pkg::ex_to_wb_t expect_i,   // valid marks a new expected entry
    input  wire rv_pipe_pkg::ex_to_wb_t retire_i,
    output int                          pending_o,
    output int                          errors_o
);

    import rv_pipe_pkg::*;

    typedef struct packed {
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       value;
        logic [31:0]               due;    // edge after which the retire must be visible
    } pending_t;

    pending_t    pending_q[$];
    pending_t    entry;
    pending_t    head;
    logic [31:0] edge_cnt = '0;
    int          push_cnt = 0;
    int          pop_cnt = 0;
    int          errors = 0;

    // row driven after edge K is sampled at K+1 and retires after edge K+2
    always @(posedge clk_i) begin
        edge_cnt <= edge_cnt + 1;
        if (expect_i.valid) begin
            entry.rd    = expect_i.rd;
            entry.value = expect_i.value;
            entry.due   = edge_cnt + 2;
            pending_q.push_back(entry);
            push_cnt++;
        end
    end

    // outputs settle after the rising edge, compare them mid-cycle
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (retire_i.valid !== 1'b0) begin
                if (pending_q.size() == 0) begin
                    $display("unexpected retire of x%0d = %08h at %0t with nothing expected",
                             retire_i.rd, retire_i.value, $time);
                    errors++;
                end else begin
                    head = pending_q.pop_front();
                    pop_cnt++;
                    if (retire_i.valid !== 1'b1 || retire_i.rd !== head.rd ||
                        retire_i.value !== head.value) begin
                        $display("MISMATCH at %0t: retire x%0d = %08h, expected x%0d = %08h",
                                 $time, retire_i.rd, retire_i.value, head.rd, head.value);
                        errors++;
                    end
                    if (edge_cnt != head.due) begin
                        $display("retire of x%0d came after edge %0d instead of edge %0d",
                                 head.rd, edge_cnt, head.due);
                        errors++;
                    end
                end
            end else if (pending_q.size() != 0 && pending_q[0].due <= edge_cnt) begin
                head = pending_q.pop_front();
                pop_cnt++;
                $display("expected retire of x%0d = %08h did not arrive by %0t",
                         head.rd, head.value, $time);
                errors++;
            end
        end
    end

    assign pending_o = push_cnt - pop_cnt;
    assign errors_o  = errors;

endmodule

`default_nettype wire

/* test/tb_rv_pipe.sv */
// table-driven run of the alu subset; register state carries over from one test to the next
`default_nettype none
`timescale 1ns/1ps

`include "rv_pipe_config.svh"

module tb_rv_pipe;

    import rv_pipe_pkg::*;

    localparam int NUM_TESTS   = 6;
    localparam int DRAIN_LIMIT = 20;   // cycles allowed for the last retires of a test
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;   // sub, sra
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    typedef struct packed {
        logic [31:0]               test;
        logic [`RV_XLEN-1:0]       instr;
        logic                      valid;
        logic [`RV_XLEN-1:0]       pc;
        logic                      retire;   // row expects a retire
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       value;
    } row_t;

    logic                      clk;
    logic                      rst;
    logic [`RV_XLEN-1:0]       instr;
    logic                      instr_valid;
    logic [`RV_XLEN-1:0]       pc;
    logic                      retire_valid;
    logic [`RV_REG_ADDR_W-1:0] retire_rd;
    logic [`RV_XLEN-1:0]       retire_value;
    ex_to_wb_t                 expect_entry;
    ex_to_wb_t                 retire_rec;
    int                        pending;
    int                        errors;
    row_t                      rows[$];
    int                        passed = 0;
    int                        failed = 0;

    rv_pipe_top rv_pipe_top_inst (
        .clk_i          (clk),
        .rst_i          (rst),
        .instr_i        (instr),
        .instr_valid_i  (instr_valid),
        .pc_i           (pc),
        .retire_valid_o (retire_valid),
        .retire_rd_o    (retire_rd),
        .retire_value_o (retire_value)
    );

    assign retire_rec = {retire_valid, retire_rd, retire_value};

    tb_retire_checker retire_checker_inst (
        .clk_i     (clk),
        .rst_i     (rst),
        .expect_i  (expect_entry),
        .retire_i  (retire_rec),
        .pending_o (pending),
        .errors_o  (errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic string test_label(input int t);
        case (t)
            0:       return "reset and zero registers";
            1:       return "immediate forms";
            2:       return "back to back dependencies";
            3:       return "dependency at distance 2 and 3";
            4:       return "bubbles and x0";
            default: return "steady stream";
        endcase
    endfunction

    task automatic add_row(input int test, input logic [31:0] word, input logic valid,
                           input logic [31:0] row_pc, input logic retire,
                           input logic [4:0] rd, input logic [31:0] value);
        row_t r;
        r.test   = test;
        r.instr  = word;
        r.valid  = valid;
        r.pc     = row_pc;
        r.retire = retire;
        r.rd     = rd;
        r.value  = value;
        rows.push_back(r);
    endtask

    task automatic add_ret(input int test, input logic [31:0] word, input logic [4:0] rd,
                           input logic [31:0] value);
        add_row(test, word, 1'b1, 32'h0000_1000, 1'b1, rd, value);
    endtask

    task automatic add_none(input int test, input logic [31:0] word, input logic valid);
        add_row(test, word, valid, 32'h0000_1000, 1'b0, 5'd0, 32'h0);
    endtask

    task automatic build_table();
        add_none(0, enc_i(12'h001, 5'd0, 3'b000, 5'd2), 1'b0);          // gap, x2 untouched
        add_none(0, 32'h0, 1'b0);
        add_ret(0, enc_r(F7_BASE, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'h0);
        add_ret(1, enc_i(12'hFFB, 5'd0, 3'b000, 5'd1), 5'd1, 32'hFFFF_FFFB);  // addi -5
        add_ret(1, enc_i(12'h003, 5'd0, 3'b000, 5'd5), 5'd5, 32'h3);
        add_ret(1, enc_i(12'hFFF, 5'd5, 3'b010, 5'd6), 5'd6, 32'h0);    // slti 3 < -1
        add_ret(1, enc_i(12'hFFF, 5'd5, 3'b011, 5'd7), 5'd7, 32'h1);    // sltiu 3 < ffffffff
        add_ret(1, enc_i(12'h401, 5'd1, 3'b101, 5'd8), 5'd8, 32'hFFFF_FFFD);  // srai 1
        add_ret(1, enc_i(12'h001, 5'd1, 3'b101, 5'd9), 5'd9, 32'h7FFF_FFFD);  // srli 1
        add_ret(1, enc_u(20'h12345, 5'd10, OPC_LUI), 5'd10, 32'h1234_5000);
        add_row(1, enc_u(20'h00010, 5'd11, OPC_AUIPC), 1'b1, 32'h0000_2000, 1'b1, 5'd11,
                32'h0001_2000);
        // each op reads the result of the row right before it
        add_ret(2, enc_i(12'h0F0, 5'd0, 3'b000, 5'd12), 5'd12, 32'hF0);
        add_ret(2, enc_i(12'h03C, 5'd0, 3'b000, 5'd13), 5'd13, 32'h3C);
        add_ret(2, enc_r(F7_ALT, 5'd13, 5'd12, 3'b000, 5'd14), 5'd14, 32'hB4);    // sub
        add_ret(2, enc_r(F7_BASE, 5'd12, 5'd14, 3'b111, 5'd15), 5'd15, 32'hB0);   // and
        add_ret(2, enc_r(F7_BASE, 5'd13, 5'd15, 3'b110, 5'd16), 5'd16, 32'hBC);   // or
        add_ret(2, enc_r(F7_BASE, 5'd12, 5'd16, 3'b100, 5'd17), 5'd17, 32'h4C);   // xor
        add_ret(2, enc_r(F7_BASE, 5'd5, 5'd17, 3'b001, 5'd18), 5'd18, 32'h260);   // sll 3
        add_ret(2, enc_r(F7_BASE, 5'd5, 5'd18, 3'b101, 5'd19), 5'd19, 32'h4C);    // srl 3
        add_ret(2, enc_r(F7_ALT, 5'd19, 5'd1, 3'b101, 5'd20), 5'd20, 32'hFFFF_FFFF);  // sra 12
        add_ret(2, enc_r(F7_BASE, 5'd5, 5'd20, 3'b010, 5'd21), 5'd21, 32'h1);     // slt -1 < 3
        add_ret(2, enc_r(F7_BASE, 5'd20, 5'd21, 3'b011, 5'd22), 5'd22, 32'h1);    // sltu
        add_ret(3, enc_i(12'h123, 5'd0, 3'b000, 5'd24), 5'd24, 32'h123);
        add_ret(3, enc_i(12'h7FF, 5'd0, 3'b000, 5'd25), 5'd25, 32'h7FF);
        add_ret(3, enc_r(F7_BASE, 5'd0, 5'd24, 3'b000, 5'd26), 5'd26, 32'h123);   // from wb
        add_ret(3, enc_r(F7_BASE, 5'd25, 5'd24, 3'b000, 5'd27), 5'd27, 32'h922);
        add_ret(3, enc_r(F7_ALT, 5'd24, 5'd25, 3'b000, 5'd28), 5'd28, 32'h6DC);   // regfile
        add_none(3, 32'h0, 1'b0);
        add_ret(3, enc_r(F7_BASE, 5'd26, 5'd27, 3'b100, 5'd29), 5'd29, 32'h801);
        add_none(4, 32'hFFFF_FFFF, 1'b1);                                // unknown opcode
        add_none(4, enc_r(F7_ALT, 5'd5, 5'd1, 3'b100, 5'd23), 1'b1);     // no alt form of xor
        add_none(4, enc_i(12'h055, 5'd0, 3'b000, 5'd4), 1'b0);
        add_none(4, enc_i(12'h007, 5'd5, 3'b000, 5'd0), 1'b1);           // rd x0
        add_ret(4, enc_r(F7_BASE, 5'd4, 5'd0, 3'b000, 5'd30), 5'd30, 32'h0);
        add_ret(4, enc_i(12'h0AA, 5'd0, 3'b100, 5'd31), 5'd31, 32'hAA);   // xori
        add_ret(5, enc_i(12'h010, 5'd2, 3'b000, 5'd2), 5'd2, 32'h10);
        add_ret(5, enc_i(12'h010, 5'd2, 3'b000, 5'd2), 5'd2, 32'h20);
        add_ret(5, enc_i(12'h010, 5'd2, 3'b000, 5'd2), 5'd2, 32'h30);
        add_ret(5, enc_i(12'h010, 5'd2, 3'b000, 5'd2), 5'd2, 32'h40);
        add_ret(5, enc_i(12'h010, 5'd2, 3'b000, 5'd2), 5'd2, 32'h50);
        add_ret(5, enc_r(F7_BASE, 5'd2, 5'd2, 3'b000, 5'd3), 5'd3, 32'hA0);
    endtask

    initial begin
        int idx;
        int errs_before;
        int waited;
        rst          = 1'b1;
        instr        = '0;
        instr_valid  = 1'b0;
        pc           = '0;
        expect_entry = '0;
        build_table();
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        idx = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = errors;
            while (idx < rows.size() && rows[idx].test == t) begin
                @(posedge clk);
                #1;
                instr              = rows[idx].instr;
                instr_valid        = rows[idx].valid;
                pc                 = rows[idx].pc;
                expect_entry.valid = rows[idx].retire;
                expect_entry.rd    = rows[idx].rd;
                expect_entry.value = rows[idx].value;
                idx++;
            end
            @(posedge clk);
            #1;
            instr_valid  = 1'b0;
            expect_entry = '0;
            // at least the fixed latency, so stray retires show up inside this test
            waited = 0;
            while ((pending != 0 || waited < 3) && waited < DRAIN_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            if (pending != 0) begin
                $display("timeout: %0d expected retires of test %0d never came out", pending, t);
                failed++;
                break;
            end
            if (errors == errs_before) begin
                passed++;
                $display("test %0d (%s): ok", t, test_label(t));
            end else begin
                failed++;
                $display("test %0d (%s): FAIL, %0d errors", t, test_label(t),
                         errors - errs_before);
            end
        end
        $display("summary: %0d ok, %0d failing", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
